// ==== sim.f ====
source/aes_cfg_pkg.sv
source/aes_field_pkg.sv
source/aes_round_if.sv
source/aes_round_ctrl.sv
source/aes_sub_shift.sv
source/aes_mix_columns.sv
source/aes_state_path.sv
source/aes_cipher_top.sv
tests/aes_cipher_props.sv
tests/tb_aes_cipher.sv

// ==== tests/tb_aes_cipher.sv ====
// Testbench for the AES cipher core with a software cipher model, a checking process and reports.

`timescale 1ns/10ps

module tb_aes_cipher;

	import aes_cfg_pkg::*;
	import aes_field_pkg::*;

	typedef logic [KEY_WORDS:1][BLOCK_W-1:0] key_bus_t;

	logic               eph1;
	logic               rst_n_i;
	logic               start_i;
	logic [1:0]         key_size_i;
	logic [BLOCK_W-1:0] plain_text_i;
	key_bus_t           key_words_i;
	logic               done_o;
	logic [BLOCK_W-1:0] cipher_o;

	// Blocks in flight, oldest first, with their accepting edge and round count.
	logic [BLOCK_W-1:0] exp_q[$];
	int                 acc_q[$];
	int                 nr_q[$];
	string              name_q[$];

	integer seed;
	int     cyc;
	int     errors;
	int     tests_run;
	int     tests_bad;

	aes_cipher_top uut (
		.eph1         (eph1),
		.rst_n_i      (rst_n_i),
		.start_i      (start_i),
		.key_size_i   (key_size_i),
		.plain_text_i (plain_text_i),
		.key_words_i  (key_words_i),
		.done_o       (done_o),
		.cipher_o     (cipher_o)
	);

	always #4 eph1 = ~eph1;

	// Counts rising edges. An output seen at a falling edge belongs to edge cyc.
	always @(posedge eph1) cyc <= cyc + 1;

	// ------------------------------------------------------------------------
	// Cipher model
	// ------------------------------------------------------------------------

	function automatic int num_rounds(input logic [1:0] ks);
		case (ks)
			2'b00:   return 10;
			2'b01:   return 12;
			default: return 14;
		endcase
	endfunction

	function automatic logic [31:0] sub_word(input logic [31:0] w);
		return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
	endfunction

	// Standard key schedule. Round key r goes to word 15 - r of the key bus.
	function automatic key_bus_t expand_key(input logic [255:0] key, input int nk);
		logic [31:0] w [60];
		logic [31:0] tmp;
		logic [7:0]  rcon;
		key_bus_t    kb;

		rcon = 8'h01;
		for (int i = 0; i < 60; i++) begin
			if (i < nk) begin
				w[i] = key[255-32*i -: 32];
			end else begin
				tmp = w[i-1];
				if (i % nk == 0) begin
					tmp  = sub_word({tmp[23:0], tmp[31:24]}) ^ {rcon, 24'h0};
					rcon = gf_mul2(rcon);
				end else if (nk > 6 && i % nk == 4) begin
					tmp = sub_word(tmp);
				end
				w[i] = w[i-nk] ^ tmp;
			end
		end
		for (int r = 0; r < KEY_WORDS; r++) begin
			kb[KEY_WORDS-r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
		end
		return kb;
	endfunction

	// Encrypts one block on a row by column matrix.
	// Byte (row r, column c) of a block sits at bits 127 - 8(4c + r).
	function automatic logic [BLOCK_W-1:0] aes_encrypt_model(input logic [BLOCK_W-1:0] pt,
			input key_bus_t keys, input logic [1:0] ks);
		logic [7:0]         m [4][4];
		logic [7:0]         t [4][4];
		logic [BLOCK_W-1:0] st;
		int                 nr;

		nr = num_rounds(ks);
		st = pt ^ keys[KEY_WORDS];
		for (int rd = 1; rd <= nr; rd++) begin
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					m[r][c] = SBOX[st[127-8*(4*c+r) -: 8]];
				end
			end
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					t[r][c] = m[r][(c+r)%4];
				end
			end
			m = t;
			// The final round leaves the columns unmixed.
			if (rd < nr) begin
				for (int c = 0; c < 4; c++) begin
					m[0][c] = gf_mul2(t[0][c]) ^ gf_mul3(t[1][c]) ^ t[2][c] ^ t[3][c];
					m[1][c] = t[0][c] ^ gf_mul2(t[1][c]) ^ gf_mul3(t[2][c]) ^ t[3][c];
					m[2][c] = t[0][c] ^ t[1][c] ^ gf_mul2(t[2][c]) ^ gf_mul3(t[3][c]);
					m[3][c] = gf_mul3(t[0][c]) ^ t[1][c] ^ t[2][c] ^ gf_mul2(t[3][c]);
				end
			end
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					st[127-8*(4*c+r) -: 8] = m[r][c];
				end
			end
			st = st ^ keys[KEY_WORDS-rd];
		end
		return st;
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------

	task automatic random_block(output logic [BLOCK_W-1:0] pt, output key_bus_t keys);
		for (int i = 0; i < 4; i++) begin
			pt[32*i +: 32] = $random(seed);
		end
		for (int w = 1; w <= KEY_WORDS; w++) begin
			for (int i = 0; i < 4; i++) begin
				keys[w][32*i +: 32] = $random(seed);
			end
		end
	endtask

	// Called at a falling edge. The start is taken at the next rising edge.
	task automatic issue_block(input logic [BLOCK_W-1:0] pt, input key_bus_t keys,
			input logic [1:0] ks, input string name);
		start_i      = 1'b1;
		key_size_i   = ks;
		plain_text_i = pt;
		key_words_i  = keys;
		exp_q.push_back(aes_encrypt_model(pt, keys, ks));
		acc_q.push_back(cyc + 1);
		nr_q.push_back(num_rounds(ks));
		name_q.push_back(name);
		@(negedge eph1);
		start_i = 1'b0;
	endtask

	task automatic drop_front();
		exp_q.delete(0);
		acc_q.delete(0);
		nr_q.delete(0);
		name_q.delete(0);
	endtask

	task automatic wait_drained(input string name);
		int n;

		n = 0;
		while (exp_q.size() != 0 && n < 40) begin
			@(negedge eph1);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %s never finished", name);
			errors++;
			exp_q.delete();
			acc_q.delete();
			nr_q.delete();
			name_q.delete();
		end
	endtask

	// The rising edge comes after all checks of the falling edge before it.
	// The task hands back the count that the next test starts from, and it
	// returns at a falling edge, ready for new stimulus.
	task automatic report_test(input string name, inout int err_start);
		@(posedge eph1);
		tests_run++;
		if (errors == err_start) begin
			$display("Test %s: ok", name);
		end else begin
			tests_bad++;
			$display("Test %s: %0d errors", name, errors - err_start);
		end
		err_start = errors;
		@(negedge eph1);
	endtask

	// ------------------------------------------------------------------------
	// Checking process
	// ------------------------------------------------------------------------

	// Outputs come from registers only, so the falling edge sees them settled.
	initial begin : check_outputs
		forever begin
			@(negedge eph1);
			if (rst_n_i && done_o !== 1'b1) begin
				if (cipher_o !== '0) begin
					$display("MISMATCH cipher_o idle: expected %h, got %h", 128'h0, cipher_o);
					errors++;
				end
				if (exp_q.size() != 0 && cyc >= acc_q[0] + nr_q[0]) begin
					$display("No done_o for %s within %0d cycles", name_q[0], nr_q[0]);
					errors++;
					drop_front();
				end
			end else if (rst_n_i) begin
				if (exp_q.size() == 0) begin
					$display("Extra done_o pulse with no block in flight");
					errors++;
				end else begin
					if (cipher_o !== exp_q[0]) begin
						$display("MISMATCH cipher_o %s: expected %h, got %h",
							name_q[0], exp_q[0], cipher_o);
						errors++;
					end
					if (cyc - acc_q[0] != nr_q[0]) begin
						$display("MISMATCH done_o latency %s: expected %h, got %h",
							name_q[0], nr_q[0], cyc - acc_q[0]);
						errors++;
					end
					drop_front();
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial begin : run_tests
		logic [BLOCK_W-1:0] pt;
		key_bus_t           keys;
		int                 err_start;
		int                 n;

		seed         = 32'h2edd;
		eph1         = 1'b0;
		rst_n_i      = 1'b0;
		start_i      = 1'b0;
		key_size_i   = KSIZE_128;
		plain_text_i = '0;
		key_words_i  = '0;
		cyc          = 0;
		errors       = 0;
		tests_run    = 0;
		tests_bad    = 0;
		err_start    = 0;
		repeat (16) @(negedge eph1);
		rst_n_i = 1'b1;

		repeat (6) @(negedge eph1);
		report_test("idle after reset", err_start);

		// Known answer for the 192-bit example key.
		keys = expand_key({192'h000102030405060708090a0b0c0d0e0f1011121314151617, 64'h0}, 6);
		pt   = 128'h00112233445566778899aabbccddeeff;
		if (aes_encrypt_model(pt, keys, KSIZE_192) !== 128'hdda97ca4864cdfe06eaf70a0ec0d7191) begin
			$display("MISMATCH model cipher: expected %h, got %h",
				128'hdda97ca4864cdfe06eaf70a0ec0d7191, aes_encrypt_model(pt, keys, KSIZE_192));
			errors++;
		end
		issue_block(pt, keys, KSIZE_192, "known answer");
		wait_drained("known answer");
		report_test("known answer", err_start);

		for (int k = 0; k < 4; k++) begin
			repeat (3) begin
				random_block(pt, keys);
				issue_block(pt, keys, 2'(k), $sformatf("random size %b", 2'(k)));
				wait_drained("random block");
			end
			report_test($sformatf("random size %b", 2'(k)), err_start);
		end

		// A second start in the middle of a block has to be dropped.
		random_block(pt, keys);
		issue_block(pt, keys, 2'b10, "busy start");
		repeat (4) @(negedge eph1);
		start_i      = 1'b1;
		plain_text_i = ~pt;
		@(negedge eph1);
		start_i = 1'b0;
		wait_drained("busy start");
		repeat (20) @(negedge eph1);
		report_test("start while busy", err_start);

		// The next start goes in during the done cycle of the first block.
		random_block(pt, keys);
		issue_block(pt, keys, KSIZE_128, "back-to-back first");
		n = 0;
		while (done_o !== 1'b1 && n < 40) begin
			@(negedge eph1);
			n++;
		end
		if (done_o !== 1'b1) begin
			$display("Timeout: done_o of the first back-to-back block never came");
			errors++;
		end
		random_block(pt, keys);
		issue_block(pt, keys, KSIZE_192, "back-to-back second");
		wait_drained("back-to-back");
		report_test("back-to-back", err_start);

		// Falling-edge checks are all counted by the time a rising edge comes.
		repeat (4) @(posedge eph1);
		errors = errors + uut.u_props.fail_cnt;
		$display("Tests run %0d, tests with errors %0d, errors %0d, assertion failures %0d",
			tests_run, tests_bad, errors, uut.u_props.fail_cnt);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== tests/aes_cipher_props.sv ====
// Bound assertions on the done pulse, the output gating and the block latency of the core.

`timescale 1ns/10ps

module aes_cipher_props (
	input logic                            eph1,
	input logic                            rst_n_i,
	input logic                            start_i,
	input logic [1:0]                      key_size_i,
	input logic                            done_i,
	input logic [aes_cfg_pkg::BLOCK_W-1:0] cipher_i
);

	// Failed assertions so far. The testbench adds this to its own error count.
	int fail_cnt = 0;

	logic in_flight;
	logic accept;

	// The core frees up on the last round edge, so the done cycle takes a start.
	assign accept = start_i & (~in_flight | done_i);

	always_ff @(posedge eph1 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_flight <= 1'b0;
		end else if (accept) begin
			in_flight <= 1'b1;
		end else if (done_i) begin
			in_flight <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Properties
	// ------------------------------------------------------------------------

	done_single: assert property (@(posedge eph1) disable iff (!rst_n_i)
		done_i |=> !done_i) else begin
		$error("done_o was high for two cycles in a row");
		fail_cnt++;
	end

	idle_zero: assert property (@(posedge eph1) disable iff (!rst_n_i)
		!done_i |-> cipher_i == '0) else begin
		$error("cipher_o was not zero outside of done_o");
		fail_cnt++;
	end

	// Done follows an accepted start after exactly 10, 12 or 14 edges.
	lat_128: assert property (@(posedge eph1) disable iff (!rst_n_i)
		accept && key_size_i == 2'b00 |=> (!done_i)[*10] ##1 done_i) else begin
		$error("done_o did not follow an AES-128 start after 10 cycles");
		fail_cnt++;
	end

	lat_192: assert property (@(posedge eph1) disable iff (!rst_n_i)
		accept && key_size_i == 2'b01 |=> (!done_i)[*12] ##1 done_i) else begin
		$error("done_o did not follow an AES-192 start after 12 cycles");
		fail_cnt++;
	end

	lat_256: assert property (@(posedge eph1) disable iff (!rst_n_i)
		accept && key_size_i[1] |=> (!done_i)[*14] ##1 done_i) else begin
		$error("done_o did not follow an AES-256 start after 14 cycles");
		fail_cnt++;
	end

endmodule

bind aes_cipher_top aes_cipher_props u_props (
	.eph1       (eph1),
	.rst_n_i    (rst_n_i),
	.start_i    (start_i),
	.key_size_i (key_size_i),
	.done_i     (done_o),
	.cipher_i   (cipher_o)
);

// ==== source/aes_cipher_top.sv ====
// Top level of the iterative AES encryption core with round controller and state path.

`timescale 1ns/10ps

module aes_cipher_top (
	input  logic                                                      eph1,
	input  logic                                                      rst_n_i,
	input  logic                                                      start_i,
	input  logic [1:0]                                                key_size_i,
	input  logic [aes_cfg_pkg::BLOCK_W-1:0]                           plain_text_i,
	input  logic [aes_cfg_pkg::KEY_WORDS:1][aes_cfg_pkg::BLOCK_W-1:0] key_words_i,
	output logic                                                      done_o,
	output logic [aes_cfg_pkg::BLOCK_W-1:0]                           cipher_o
);

	// Round control shared by the controller and the datapath.
	aes_round_if rnd_if ();

	// The controller owns all of the latency and picks the round key.
	aes_round_ctrl u_round_ctrl (
		.eph1        (eph1),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.key_size_i  (key_size_i),
		.key_words_i (key_words_i),
		.rnd         (rnd_if.ctrl)
	);

	// One round per clock on the single state register.
	aes_state_path u_state_path (
		.eph1         (eph1),
		.rst_n_i      (rst_n_i),
		.plain_text_i (plain_text_i),
		.rnd          (rnd_if.path),
		.cipher_o     (cipher_o)
	);

	assign done_o = rnd_if.done;

endmodule

// ==== source/aes_state_path.sv ====
// Cipher state register with whitening, one AES round, AddRoundKey and output gating.

`timescale 1ns/10ps

module aes_state_path (
	input  logic                            eph1,
	input  logic                            rst_n_i,
	input  logic [aes_cfg_pkg::BLOCK_W-1:0] plain_text_i,
	aes_round_if.path                       rnd,
	output logic [aes_cfg_pkg::BLOCK_W-1:0] cipher_o
);

	import aes_cfg_pkg::*;

	aes_state_u         state_q;
	aes_state_u         shifted;
	aes_state_u         mixed;
	logic [BLOCK_W-1:0] round_res;

	// One full round on the registered state.
	aes_sub_shift u_sub_shift (
		.state_i (state_q),
		.state_o (shifted)
	);

	aes_mix_columns u_mix_columns (
		.state_i (shifted),
		.state_o (mixed)
	);

	// The last round bypasses MixColumns before the key is added.
	assign round_res = (rnd.last ? shifted.flat : mixed.flat) ^ rnd.round_key;

	// A load whitens the plaintext with word 15. Every other edge writes the
	// round result, and in idle that value is never shown.
	always_ff @(posedge eph1 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q.flat <= '0;
		end else if (rnd.load) begin
			state_q.flat <= plain_text_i ^ rnd.round_key;
		end else begin
			state_q.flat <= round_res;
		end
	end

	// After the last round the register holds the ciphertext for one cycle.
	assign cipher_o = rnd.done ? state_q.flat : '0;

endmodule

// ==== source/aes_mix_columns.sv ====
// Combinational MixColumns over the four columns of a cipher state.

`timescale 1ns/10ps

module aes_mix_columns (
	input  aes_cfg_pkg::aes_state_u state_i,
	output aes_cfg_pkg::aes_state_u state_o
);

	import aes_cfg_pkg::*;
	import aes_field_pkg::*;

	// Each column is multiplied by the circulant matrix
	//   | 2 3 1 1 |
	//   | 1 2 3 1 |
	//   | 1 1 2 3 |
	//   | 3 1 1 2 |
	// where products are taken in GF(2^8) and sums are XOR.
	always_comb begin
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		int         top;

		for (int c = 0; c < 4; c++) begin
			// Row 0 of column c is the highest byte index of that column.
			top = BLOCK_BYTES - 1 - 4 * c;
			a0  = state_i.bytes[top];
			a1  = state_i.bytes[top-1];
			a2  = state_i.bytes[top-2];
			a3  = state_i.bytes[top-3];

			state_o.bytes[top]   = gf_mul2(a0) ^ gf_mul3(a1) ^ a2 ^ a3;
			state_o.bytes[top-1] = a0 ^ gf_mul2(a1) ^ gf_mul3(a2) ^ a3;
			state_o.bytes[top-2] = a0 ^ a1 ^ gf_mul2(a2) ^ gf_mul3(a3);
			state_o.bytes[top-3] = gf_mul3(a0) ^ a1 ^ a2 ^ gf_mul2(a3);
		end
	end

endmodule

// ==== source/aes_sub_shift.sv ====
// Combinational SubBytes followed by ShiftRows on one cipher state.

`timescale 1ns/10ps

module aes_sub_shift (
	input  aes_cfg_pkg::aes_state_u state_i,
	output aes_cfg_pkg::aes_state_u state_o
);

	import aes_cfg_pkg::*;
	import aes_field_pkg::*;

	aes_state_u sub_bytes;

	// Every byte goes through the S-box on its own.
	always_comb begin
		for (int i = 0; i < BLOCK_BYTES; i++) begin
			sub_bytes.bytes[i] = SBOX[state_i.bytes[i]];
		end
	end

	// Row r of the matrix rotates left by r columns.
	// Byte (row r, column c) sits at index 15 - 4c - r, and it takes the
	// byte found at row r, column (c + r) mod 4.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				state_o.bytes[BLOCK_BYTES-1-4*c-r] =
					sub_bytes.bytes[BLOCK_BYTES-1-4*((c+r)%4)-r];
			end
		end
	end

endmodule

// ==== source/aes_round_ctrl.sv ====
// Round controller with the in-flight flag, round counter, key select and done strobe.

`timescale 1ns/10ps

module aes_round_ctrl (
	input  logic                                                      eph1,
	input  logic                                                      rst_n_i,
	input  logic                                                      start_i,
	input  logic [1:0]                                                key_size_i,
	input  logic [aes_cfg_pkg::KEY_WORDS:1][aes_cfg_pkg::BLOCK_W-1:0] key_words_i,
	aes_round_if.ctrl                                                 rnd
);

	import aes_cfg_pkg::*;

	logic               busy_q;
	logic               done_q;
	logic [ROUND_W-1:0] round_q;
	logic [ROUND_W-1:0] nr_q;
	logic [ROUND_W-1:0] nr_sel;
	logic [ROUND_W-1:0] key_idx;
	logic               load;
	logic               last;

	// Round count for the requested key size. Codes 10 and 11 both mean 256.
	always_comb begin
		case (key_size_i)
			KSIZE_128: nr_sel = ROUNDS_128;
			KSIZE_192: nr_sel = ROUNDS_192;
			default:   nr_sel = ROUNDS_256;
		endcase
	end

	// A start only counts while no block is in flight.
	assign load = start_i & ~busy_q;

	// The final round has no MixColumns.
	assign last = busy_q & (round_q == nr_q);

	// ------------------------------------------------------------------------
	// Round counter and flags
	// ------------------------------------------------------------------------

	// Round r runs in the cycle after the edge that wrote round r - 1, so the
	// counter starts at 1 straight after the accepting edge.
	// The busy flag drops on the edge of the last round. That is why the
	// done cycle can already accept the next start.
	always_ff @(posedge eph1 or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			round_q <= '0;
			nr_q    <= '0;
		end else begin
			done_q <= last;
			if (load) begin
				busy_q  <= 1'b1;
				round_q <= ROUND_W'(1);
				nr_q    <= nr_sel;
			end else if (last) begin
				busy_q <= 1'b0;
			end else if (busy_q) begin
				round_q <= round_q + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Round key select
	// ------------------------------------------------------------------------

	// Word 15 whitens the plaintext, and round r takes word 15 - r.
	// When idle the whitening word is presented, ready for the next load.
	assign key_idx = busy_q ? ROUND_W'(KEY_WORDS) - round_q : ROUND_W'(KEY_WORDS);

	assign rnd.round_key = key_words_i[key_idx];
	assign rnd.load      = load;
	assign rnd.last      = last;
	assign rnd.done      = done_q;

endmodule

// ==== source/aes_round_if.sv ====
// Round control interface between the round controller and the state path.

`timescale 1ns/10ps

interface aes_round_if;

	import aes_cfg_pkg::*;

	// High in the cycle in which a start is accepted.
	logic load;

	// High in the cycle whose edge writes the final round.
	logic last;

	// High for one cycle after the final round has been written.
	logic done;

	// Key word for the whitening step or for the current round.
	logic [BLOCK_W-1:0] round_key;

	// The controller drives everything and the state path only listens.
	modport ctrl (output load, output last, output done, output round_key);
	modport path (input load, input last, input done, input round_key);

endinterface

// ==== source/aes_field_pkg.sv ====
// AES S-box table and the GF(2^8) multiply-by-2 and multiply-by-3 functions.

package aes_field_pkg;

	// Reduction constant of the AES field polynomial x^8 + x^4 + x^3 + x + 1.
	localparam logic [7:0] GF_POLY = 8'h1b;

	// Forward S-box. The entry at index v is the substitution of byte v,
	// so index 0 (the leftmost entry) gives 63 hex.
	localparam logic [0:255][7:0] SBOX = {
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// Multiply by 2 is a left shift. When the top bit falls out, the product
	// is reduced by the field polynomial.
	function automatic logic [7:0] gf_mul2(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? GF_POLY : 8'h00);
	endfunction

	// Multiply by 3 is (2 * b) + b, and field addition is XOR.
	function automatic logic [7:0] gf_mul3(input logic [7:0] b);
		return gf_mul2(b) ^ b;
	endfunction

endpackage

// ==== source/aes_cfg_pkg.sv ====
// Block geometry, key-size codes, round counts and the cipher state type.

package aes_cfg_pkg;

	// ------------------------------------------------------------------------
	// Block and key geometry
	// ------------------------------------------------------------------------

	// One cipher block is 128 bits wide, which is sixteen bytes.
	localparam int BLOCK_W     = 128;
	localparam int BLOCK_BYTES = 16;

	// Round-key words arrive already expanded. Word 15 is the whitening key,
	// and word 15 - r is used in round r, down to word 1 for AES-256.
	localparam int KEY_WORDS = 15;

	// ------------------------------------------------------------------------
	// Key sizes and round counts
	// ------------------------------------------------------------------------

	// Codes for the key_size input. Any code with the upper bit set means 256.
	localparam logic [1:0] KSIZE_128 = 2'b00;
	localparam logic [1:0] KSIZE_192 = 2'b01;

	// The round counter has to hold values up to 14.
	localparam int ROUND_W = 4;

	localparam logic [ROUND_W-1:0] ROUNDS_128 = 4'd10;
	localparam logic [ROUND_W-1:0] ROUNDS_192 = 4'd12;
	localparam logic [ROUND_W-1:0] ROUNDS_256 = 4'd14;

	// The cipher state seen as one flat word or as sixteen bytes.
	// Byte 15 is the first byte of the block (bits 127:120).
	// Bytes are column-major, so column 0 is bytes 15 down to 12, with the
	// row 0 byte at the top of each column.
	typedef union packed {
		logic [BLOCK_W-1:0]          flat;
		logic [BLOCK_BYTES-1:0][7:0] bytes;
	} aes_state_u;

endpackage
